// File: run.sh
#!/bin/sh
# Build and run the accumulator CPU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cpu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: sim.f
+incdir+tb
source/isa_pkg.sv
source/ctrl_pkg.sv
source/sequencer.sv
source/alu.sv
source/acc_unit.sv
source/memory.sv
source/bus_regs.sv
source/cpu_top.sv
tb/tb_cpu.sv

// File: source/acc_unit.sv
// Accumulator and flag register.
// Loads from the bus or runs INC, DEC and NOT in place.
// Carry changes on INC/DEC and on ADD/SUB results while zero tracks acc.
`timescale 1ns/1ns

module acc_unit (
    input  logic                 clk,
    input  logic                 stage_rst,
    input  ctrl_pkg::ctrl_word_t ctrl,
    input  isa_pkg::word_t       bus,
    input  logic                 alu_carry,
    output isa_pkg::word_t       acc,
    output ctrl_pkg::flags_t     flags
);

    logic carry;
    logic arith_load;

    // accumulator load of an ADD or SUB result
    assign arith_load = ctrl.acc_load && (ctrl.bus_src == ctrl_pkg::ALU)
                        && (ctrl.alu_op == ctrl_pkg::ADD || ctrl.alu_op == ctrl_pkg::SUB);

    always_ff @(posedge clk) begin
        if (stage_rst) begin
            acc <= '0;
            carry <= 1'b0;
        end else if (ctrl.acc_load) begin
            acc <= bus;
            if (arith_load) begin
                carry <= alu_carry;
            end
        end else begin
            case (ctrl.acc_op)
                ctrl_pkg::INC: {carry, acc} <= {1'b0, acc} + 17'd1;
                ctrl_pkg::DEC: {carry, acc} <= {1'b0, acc} - 17'd1;  // borrow from 0
                ctrl_pkg::NOT: acc <= ~acc;                          // carry kept
                default: ;
            endcase
        end
    end

    assign flags = '{zero: (acc == '0), carry: carry};

endmodule

// File: source/alu.sv
// Two-operand ALU of the accumulator CPU.
// ADD and SUB give carry and borrow while the logic ops give carry 0.
`timescale 1ns/1ns

module alu (
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    input  ctrl_pkg::alu_op_e alu_op,
    output isa_pkg::word_t    result,
    output logic              carry
);

    logic [16:0] wide;  // bit 16 is carry out or borrow

    always_comb begin
        case (alu_op)
            ctrl_pkg::ADD: wide = {1'b0, a} + {1'b0, b};
            ctrl_pkg::SUB: wide = {1'b0, a} - {1'b0, b};  // wraps to 1 when a < b
            ctrl_pkg::AND: wide = {1'b0, a & b};
            ctrl_pkg::OR:  wide = {1'b0, a | b};
            ctrl_pkg::XOR: wide = {1'b0, a ^ b};
            default:       wide = '0;
        endcase
    end

    assign result = wide[15:0];
    assign carry = wide[16];

endmodule

// File: source/bus_regs.sv
// Bus source selection with PC, instruction register and B register.
// The PC is ADDR_W bits wide, wraps at that width and is
// zero-extended when it drives the bus.
`timescale 1ns/1ns

module bus_regs #(
    parameter int ADDR_W = 12
) (
    input  logic                 clk,
    input  logic                 stage_rst,
    input  ctrl_pkg::ctrl_word_t ctrl,
    input  isa_pkg::word_t       acc,
    input  isa_pkg::word_t       alu_result,
    input  isa_pkg::word_t       mem_rdata,
    output isa_pkg::word_t       bus,
    output isa_pkg::instr_t      ir,
    output isa_pkg::word_t       b
);

    logic [ADDR_W-1:0] pc;

    always_comb begin
        case (ctrl.bus_src)
            ctrl_pkg::ACC: bus = acc;
            ctrl_pkg::ALU: bus = alu_result;
            ctrl_pkg::MEM: bus = mem_rdata;
            ctrl_pkg::PC:  bus = isa_pkg::word_t'(pc);
            ctrl_pkg::IR:  bus = ir;
            default:       bus = '0;  // idle bus
        endcase
    end

    always_ff @(posedge clk) begin
        if (stage_rst) begin
            pc <= '0;
            b <= '0;
        end else begin
            if (ctrl.pc_load) begin
                pc <= bus[ADDR_W-1:0];  // jump target
            end else if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.b_load) begin
                b <= bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_load) begin
            ir <= bus;
        end
    end

endmodule

// File: source/cpu_top.sv
// Top level of the multi-cycle accumulator CPU.
// Sequencer, ALU, accumulator, bus registers and shared memory
// on one 16-bit bus, plus a strobe that shows every STORE.
`timescale 1ns/1ns

module cpu_top #(
    parameter int ADDR_W = 12
) (
    input  logic                 clk,
    input  logic                 stage_rst,
    input  logic                 load_we,
    input  isa_pkg::addr_field_t load_addr,
    input  isa_pkg::word_t       load_data,
    output isa_pkg::store_evt_t  store,
    output isa_pkg::word_t       acc
);

    ctrl_pkg::ctrl_word_t ctrl;
    ctrl_pkg::flags_t     flags;
    isa_pkg::word_t       bus;
    isa_pkg::word_t       mem_rdata;
    isa_pkg::word_t       alu_result;
    isa_pkg::word_t       b;
    isa_pkg::instr_t      ir;
    isa_pkg::addr_field_t mar;
    logic                 alu_carry;

    sequencer u_sequencer (
        .clk       (clk),
        .stage_rst (stage_rst),
        .mem_rdata (mem_rdata),
        .ir        (ir),
        .flags     (flags),
        .ctrl      (ctrl)
    );

    alu u_alu (
        .a      (acc),
        .b      (b),
        .alu_op (ctrl.alu_op),
        .result (alu_result),
        .carry  (alu_carry)
    );

    acc_unit u_acc_unit (
        .clk       (clk),
        .stage_rst (stage_rst),
        .ctrl      (ctrl),
        .bus       (bus),
        .alu_carry (alu_carry),
        .acc       (acc),
        .flags     (flags)
    );

    memory #(.ADDR_W(ADDR_W)) u_memory (
        .clk       (clk),
        .stage_rst (stage_rst),
        .ctrl      (ctrl),
        .bus       (bus),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (mem_rdata),
        .mar       (mar)
    );

    bus_regs #(.ADDR_W(ADDR_W)) u_bus_regs (
        .clk        (clk),
        .stage_rst  (stage_rst),
        .ctrl       (ctrl),
        .acc        (acc),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .bus        (bus),
        .ir         (ir),
        .b          (b)
    );

    // acc is on the bus during the write step
    assign store = '{valid: ctrl.mem_write, addr: mar, data: bus};

endmodule

// File: source/ctrl_pkg.sv
// Control package for the accumulator CPU.
// Step sequence, bus sources, ALU and accumulator operations,
// the flag pair and the control word sent to every unit.
package ctrl_pkg;

    typedef enum logic [2:0] {
        FETCH_ADDR,
        FETCH_READ,
        OPERAND_ADDR,
        MEM_ACCESS,
        EXECUTE
    } step_e;

    typedef enum logic [2:0] {NONE, ACC, B, ALU, MEM, PC, IR} bus_src_e;
    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;
    typedef enum logic [1:0] {HOLD, INC, DEC, NOT} acc_op_e;

    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

    typedef struct packed {
        bus_src_e bus_src;   // who drives the bus
        logic     mar_load;
        logic     mem_read;  // data valid in rdata next step
        logic     mem_write;
        logic     acc_load;
        logic     b_load;
        logic     pc_load;
        logic     pc_inc;
        logic     ir_load;
        alu_op_e  alu_op;
        acc_op_e  acc_op;    // in-place accumulator op
    } ctrl_word_t;

endpackage

// File: source/isa_pkg.sv
// Instruction set package for the 16-bit accumulator CPU.
// Word and address field types, opcode encodings, the NOARG
// sub-operations and the store event seen at the top level.
package isa_pkg;

    typedef logic [15:0] word_t;        // data and instruction word
    typedef logic [11:0] addr_field_t;  // address field of an instruction

    // top nibble of the word where unlisted codes run as NOOP
    typedef enum logic [3:0] {
        NOARG = 4'd0,
        LOADA = 4'd1,
        STORE = 4'd2,
        ADD   = 4'd3,
        SUB   = 4'd5,
        AND   = 4'd8,
        OR    = 4'd9,
        XOR   = 4'd10,
        JMP   = 4'd11,
        JMPZ  = 4'd12,
        JMPC  = 4'd13
    } opcode_e;

    typedef enum logic [11:0] {
        NOOP = 12'd0,
        INC  = 12'd1,
        DEC  = 12'd2,
        NOT  = 12'd5
    } noarg_e;  // arg of a NOARG instruction

    typedef struct packed {
        opcode_e     opcode;
        addr_field_t arg;     // address, jump target or noarg op
    } instr_t;

    typedef struct packed {
        logic        valid;   // one cycle per STORE
        addr_field_t addr;
        word_t       data;
    } store_evt_t;

endpackage

// File: source/memory.sv
// Unified program and data memory.
// MAR, read register and a load port that writes only in reset.
// A read issued with a MAR load takes its address straight off the bus.
`timescale 1ns/1ns

module memory #(
    parameter int ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  stage_rst,
    input  ctrl_pkg::ctrl_word_t  ctrl,
    input  isa_pkg::word_t        bus,
    input  logic                  load_we,
    input  isa_pkg::addr_field_t  load_addr,
    input  isa_pkg::word_t        load_data,
    output isa_pkg::word_t        rdata,
    output isa_pkg::addr_field_t  mar
);

    isa_pkg::word_t    mem_array [2**ADDR_W];
    logic [ADDR_W-1:0] rd_addr;

    // new address when the MAR loads in the same cycle
    assign rd_addr = ctrl.mar_load ? bus[ADDR_W-1:0] : mar[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (ctrl.mar_load) begin
            mar <= isa_pkg::addr_field_t'(bus);
        end
        if (ctrl.mem_read) begin
            rdata <= mem_array[rd_addr];
        end
        if (stage_rst) begin
            if (load_we) begin
                mem_array[load_addr[ADDR_W-1:0]] <= load_data;  // program image
            end
        end else if (ctrl.mem_write) begin
            mem_array[mar[ADDR_W-1:0]] <= bus;
        end
    end

endmodule

// File: source/sequencer.sv
// Step sequencer of the accumulator CPU.
// Counts the steps of the instruction in flight and decodes step
// and instruction into the control word for the datapath.
`timescale 1ns/1ns

module sequencer (
    input  logic                 clk,
    input  logic                 stage_rst,
    input  isa_pkg::word_t       mem_rdata,
    input  isa_pkg::instr_t      ir,
    input  ctrl_pkg::flags_t     flags,
    output ctrl_pkg::ctrl_word_t ctrl
);

    ctrl_pkg::step_e step;
    ctrl_pkg::step_e step_next;
    isa_pkg::instr_t fetched;

    assign fetched = mem_rdata;  // instruction word from the read register

    always_ff @(posedge clk) begin
        if (stage_rst) begin
            step <= ctrl_pkg::FETCH_ADDR;
        end else begin
            step <= step_next;
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.bus_src = ctrl_pkg::NONE;
        ctrl.alu_op = ctrl_pkg::ADD;
        ctrl.acc_op = ctrl_pkg::HOLD;
        step_next = ctrl_pkg::FETCH_ADDR;  // most paths end the instruction
        case (step)
            ctrl_pkg::FETCH_ADDR: begin
                ctrl.bus_src = ctrl_pkg::PC;
                ctrl.mar_load = 1'b1;
                ctrl.mem_read = 1'b1;
                step_next = ctrl_pkg::FETCH_READ;
            end
            ctrl_pkg::FETCH_READ: begin
                ctrl.bus_src = ctrl_pkg::MEM;  // instruction on the bus
                case (fetched.opcode)
                    isa_pkg::NOARG: begin
                        ctrl.pc_inc = 1'b1;
                        case (fetched.arg)
                            isa_pkg::INC: ctrl.acc_op = ctrl_pkg::INC;
                            isa_pkg::DEC: ctrl.acc_op = ctrl_pkg::DEC;
                            isa_pkg::NOT: ctrl.acc_op = ctrl_pkg::NOT;
                            default:      ctrl.acc_op = ctrl_pkg::HOLD;
                        endcase
                    end
                    isa_pkg::JMP:  ctrl.pc_load = 1'b1;
                    isa_pkg::JMPZ: begin
                        ctrl.pc_load = flags.zero;
                        ctrl.pc_inc = ~flags.zero;
                    end
                    isa_pkg::JMPC: begin
                        ctrl.pc_load = flags.carry;
                        ctrl.pc_inc = ~flags.carry;
                    end
                    isa_pkg::LOADA, isa_pkg::STORE, isa_pkg::ADD, isa_pkg::SUB,
                    isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR: begin
                        ctrl.pc_inc = 1'b1;
                        ctrl.ir_load = 1'b1;
                        step_next = ctrl_pkg::OPERAND_ADDR;
                    end
                    default: ctrl.pc_inc = 1'b1;  // unkept opcode
                endcase
            end
            ctrl_pkg::OPERAND_ADDR: begin
                ctrl.bus_src = ctrl_pkg::IR;  // low 12 bits are the address
                ctrl.mar_load = 1'b1;
                ctrl.mem_read = (fetched.opcode != isa_pkg::STORE);
                step_next = ctrl_pkg::MEM_ACCESS;
            end
            ctrl_pkg::MEM_ACCESS: begin
                case (ir.opcode)
                    isa_pkg::LOADA: begin
                        ctrl.bus_src = ctrl_pkg::MEM;
                        ctrl.acc_load = 1'b1;
                    end
                    isa_pkg::STORE: begin
                        ctrl.bus_src = ctrl_pkg::ACC;
                        ctrl.mem_write = 1'b1;
                    end
                    default: begin  // ALU operand into B
                        ctrl.bus_src = ctrl_pkg::MEM;
                        ctrl.b_load = 1'b1;
                        step_next = ctrl_pkg::EXECUTE;
                    end
                endcase
            end
            ctrl_pkg::EXECUTE: begin
                ctrl.bus_src = ctrl_pkg::ALU;
                ctrl.acc_load = 1'b1;
                case (ir.opcode)
                    isa_pkg::SUB: ctrl.alu_op = ctrl_pkg::SUB;
                    isa_pkg::AND: ctrl.alu_op = ctrl_pkg::AND;
                    isa_pkg::OR:  ctrl.alu_op = ctrl_pkg::OR;
                    isa_pkg::XOR: ctrl.alu_op = ctrl_pkg::XOR;
                    default:      ctrl.alu_op = ctrl_pkg::ADD;
                endcase
            end
            default: step_next = ctrl_pkg::FETCH_ADDR;
        endcase
    end

endmodule

// File: tb/cpu_model.svh
// Reference model of the accumulator CPU for the testbench.
// Steps through the image of the including testbench until the
// self-jump, queues the expected stores and gives the final acc.
// Also holds the LCG used to draw random programs.
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// next state of the stimulus generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

function automatic void execute_image(output isa_pkg::word_t final_acc,
                                      output int exec_count);
    isa_pkg::word_t      mem [MEM_WORDS];
    isa_pkg::instr_t     ins;
    isa_pkg::word_t      a;
    isa_pkg::word_t      m;
    isa_pkg::store_evt_t evt;
    logic                carry;
    logic [ADDR_W-1:0]   pc;
    logic [ADDR_W-1:0]   next_pc;
    logic [ADDR_W-1:0]   ea;
    logic                halted;
    int                  steps;
    int                  sum;
    mem = image;
    a = '0;
    carry = 1'b0;
    pc = '0;
    halted = 1'b0;
    steps = 0;
    exec_count = 0;
    while (!halted && steps < 20000) begin
        ins = mem[pc];
        ea = ins.arg[ADDR_W-1:0];  // memory wraps at ADDR_W bits
        m = mem[ea];
        next_pc = pc + 1'b1;
        steps++;
        case (ins.opcode)
            isa_pkg::LOADA: a = m;
            isa_pkg::STORE: begin
                mem[ea] = a;
                evt.valid = 1'b1;
                evt.addr = ins.arg;
                evt.data = a;
                expected_stores.push_back(evt);
                exec_count = steps;  // count up to the last store
            end
            isa_pkg::ADD: begin
                sum = int'(a) + int'(m);
                carry = (sum > 65535);
                a = 16'(sum);
            end
            isa_pkg::SUB: begin
                carry = (a < m);  // borrow
                a = a - m;
            end
            isa_pkg::AND: a = a & m;
            isa_pkg::OR:  a = a | m;
            isa_pkg::XOR: a = a ^ m;
            isa_pkg::NOARG: begin
                if (ins.arg == isa_pkg::INC) begin
                    carry = (a == 16'hFFFF);
                    a = a + 16'd1;
                end else if (ins.arg == isa_pkg::DEC) begin
                    carry = (a == 16'h0000);
                    a = a - 16'd1;
                end else if (ins.arg == isa_pkg::NOT) begin
                    a = ~a;
                end
            end
            isa_pkg::JMP: begin
                halted = (ea == pc);
                next_pc = ea;
            end
            isa_pkg::JMPZ: if (a == 16'h0000) next_pc = ea;
            isa_pkg::JMPC: if (carry) next_pc = ea;
            default: ;  // unkept opcode
        endcase
        pc = next_pc;
    end
    final_acc = a;
endfunction

`endif

// File: tb/tb_cpu.sv
// Testbench for the multi-cycle accumulator CPU.
// Loads each program through the load port during reset, checks
// every store strobe against the reference model, then the final acc.
`timescale 1ns/1ns

module tb_cpu;

    localparam int ADDR_W = 10;
    localparam int MEM_WORDS = 1 << ADDR_W;

    logic                 clk;
    logic                 stage_rst;
    logic                 load_we;
    isa_pkg::addr_field_t load_addr;
    isa_pkg::word_t       load_data;
    isa_pkg::store_evt_t  store;
    isa_pkg::word_t       acc;

    isa_pkg::word_t       image [MEM_WORDS];
    isa_pkg::store_evt_t  expected_stores [$];
    int                   prog_len;
    int                   run_cycles;
    int                   cycle_limit;
    logic [31:0]          lcg_state;

    cpu_top #(.ADDR_W(ADDR_W)) dut (
        .clk       (clk),
        .stage_rst (stage_rst),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .store     (store),
        .acc       (acc)
    );

    `include "cpu_model.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic emit(input logic [3:0] op, input logic [11:0] arg);
        image[prog_len] = {op, arg};
        prog_len++;
    endtask

    // store acc, then park on a self-jump
    task automatic end_program(input logic [11:0] addr);
        emit(isa_pkg::STORE, addr);
        emit(isa_pkg::JMP, 12'(prog_len));
    endtask

    task automatic clear_image();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            image[a] = 16'hE000 | 16'(a);  // unkept opcode that runs as NOOP
        end
        prog_len = 0;
    endtask

    task automatic copy_program();
        clear_image();
        image['h200] = 16'h1234;
        image['h201] = 16'hBEEF;
        emit(isa_pkg::LOADA, 12'h200);
        emit(isa_pkg::STORE, 12'h300);
        emit(isa_pkg::LOADA, 12'h201);
        emit(isa_pkg::STORE, 12'h301);
        emit(isa_pkg::LOADA, 12'h300);  // read back a stored copy
        emit(isa_pkg::STORE, 12'h302);
        end_program(12'h303);
    endtask

    task automatic arith_program();
        clear_image();
        image['h200] = 16'hFFF0;
        image['h201] = 16'h0020;
        image['h202] = 16'h0005;
        image['h203] = 16'h0001;
        emit(isa_pkg::LOADA, 12'h200);
        emit(isa_pkg::ADD, 12'h201);              // wraps and sets carry
        emit(isa_pkg::STORE, 12'h300);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));   // taken
        emit(isa_pkg::STORE, 12'h301);
        emit(isa_pkg::ADD, 12'h202);              // carry clear
        emit(isa_pkg::STORE, 12'h302);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));   // falls through
        emit(isa_pkg::STORE, 12'h303);
        emit(isa_pkg::SUB, 12'h201);              // borrow
        emit(isa_pkg::STORE, 12'h304);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));
        emit(isa_pkg::STORE, 12'h305);
        emit(isa_pkg::SUB, 12'h203);
        end_program(12'h306);
    endtask

    task automatic logic_program();
        clear_image();
        image['h200] = 16'hFFFF;
        image['h201] = 16'h0001;
        image['h202] = 16'h0F0F;
        image['h203] = 16'h3355;
        emit(isa_pkg::LOADA, 12'h200);
        emit(isa_pkg::ADD, 12'h201);              // carry set
        emit(isa_pkg::LOADA, 12'h202);
        emit(isa_pkg::AND, 12'h203);
        emit(isa_pkg::STORE, 12'h300);
        emit(isa_pkg::OR, 12'h203);
        emit(isa_pkg::STORE, 12'h301);
        emit(isa_pkg::XOR, 12'h202);
        emit(isa_pkg::STORE, 12'h302);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));   // carry survived
        emit(isa_pkg::STORE, 12'h303);
        emit(isa_pkg::ADD, 12'h201);              // clears carry
        emit(isa_pkg::AND, 12'h200);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));
        emit(isa_pkg::STORE, 12'h304);
        end_program(12'h305);
    endtask

    task automatic loop_program();
        clear_image();
        image['h200] = 16'h0005;
        emit(isa_pkg::LOADA, 12'h200);
        emit(isa_pkg::STORE, 12'h300);            // loop top at 1
        emit(4'h7, 12'h123);                      // unkept opcode
        emit(isa_pkg::NOARG, isa_pkg::DEC);
        emit(isa_pkg::JMPZ, 12'(prog_len + 2));
        emit(isa_pkg::JMP, 12'h001);
        emit(isa_pkg::NOARG, isa_pkg::NOT);
        emit(isa_pkg::NOARG, isa_pkg::INC);       // wraps to zero
        emit(isa_pkg::NOARG, 12'h003);            // unused noarg code
        emit(isa_pkg::STORE, 12'h301);
        emit(isa_pkg::JMPC, 12'(prog_len + 2));
        emit(isa_pkg::STORE, 12'h302);
        emit(isa_pkg::NOARG, isa_pkg::DEC);       // borrow from zero
        emit(isa_pkg::NOARG, isa_pkg::NOT);
        end_program(12'h303);
    endtask

    // 40 straight-line instructions over data at 0x200..0x20F
    task automatic random_program();
        logic [31:0] r;
        logic [11:0] addr;
        int          i;
        clear_image();
        for (i = 0; i < 16; i++) begin
            lcg_state = lcg_next(lcg_state);
            image['h200 + i] = lcg_state[31:16];
        end
        for (i = 0; i < 40; i++) begin
            lcg_state = lcg_next(lcg_state);
            r = lcg_state >> 16;
            addr = 12'h200 + 12'(r[3:0]);
            case (int'(r[15:8]) % 10)
                0: emit(isa_pkg::LOADA, addr);
                1: emit(isa_pkg::STORE, addr);
                2: emit(isa_pkg::ADD, addr);
                3: emit(isa_pkg::SUB, addr);
                4: emit(isa_pkg::AND, addr);
                5: emit(isa_pkg::OR, addr);
                6: emit(isa_pkg::XOR, addr);
                7: emit(isa_pkg::NOARG, (r[5:4] == 2'd3) ? 12'd5 : 12'(r[5:4]));
                8: emit(isa_pkg::JMPZ, 12'(prog_len + 1));  // either way to next
                default: emit(isa_pkg::JMPC, 12'(prog_len + 1));
            endcase
        end
        end_program(12'h300);
    endtask

    task automatic reset_and_load();
        int a;
        @(posedge clk);
        #1;
        stage_rst = 1'b1;
        for (a = 0; a < MEM_WORDS; a++) begin
            load_we = 1'b1;
            load_addr = 12'(a);
            load_data = image[a];
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        stage_rst = 1'b0;
    endtask

    task automatic check_program(input string name);
        isa_pkg::word_t final_acc;
        int             exec_count;
        execute_image(final_acc, exec_count);
        cycle_limit += 5 * exec_count + 20;
        reset_and_load();
        while (expected_stores.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        assert (acc === final_acc)
            else abort_run($sformatf("[ERROR] acc got 0x%h expected 0x%h", acc, final_acc));
        $display("finished %s after %0d instructions", name, exec_count);
    endtask

    // every store strobe against the next expected event
    always @(negedge clk) begin : store_check
        isa_pkg::store_evt_t evt;
        if (stage_rst) begin
            assert (store.valid === 1'b0)
                else abort_run("store strobe raised while in reset");
        end else if (store.valid) begin
            assert (expected_stores.size() != 0)
                else abort_run($sformatf("unexpected extra store to address 0x%h", store.addr));
            evt = expected_stores.pop_front();
            assert (store.addr === evt.addr)
                else abort_run($sformatf("[ERROR] store.addr got 0x%h expected 0x%h",
                                         store.addr, evt.addr));
            assert (store.data === evt.data)
                else abort_run($sformatf("[ERROR] store.data got 0x%h expected 0x%h",
                                         store.data, evt.data));
        end
    end

    always @(posedge clk) begin
        if (!stage_rst) begin
            run_cycles++;
            assert (run_cycles < cycle_limit)
                else abort_run($sformatf("timeout after %0d cycles with %0d stores missing",
                                         run_cycles, expected_stores.size()));
        end
    end

    initial begin
        stage_rst = 1'b1;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        run_cycles = 0;
        cycle_limit = 0;
        lcg_state = 32'h5086;
        copy_program();
        check_program("load and store copy");
        arith_program();
        check_program("add and sub with carry");
        logic_program();
        check_program("logic ops");
        loop_program();
        check_program("inc dec not loop");
        repeat (3) begin
            random_program();
            check_program("random program");
        end
        $display("TEST PASS");
        $finish;
    end

endmodule
